/* flist.f */
design/dzPkg.sv
design/dzSilo.sv
design/dzTxScan.sv
design/dzIntr.sv
design/dzRegs.sv
design/dzTop.sv
verif/dzTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module dzTb -Mdir obj_dir -o dzSim -f flist.f
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

simOut="$(./obj_dir/dzSim 2>&1)"
simStatus=$?
echo "$simOut"
if [ $simStatus -ne 0 ]; then
   echo "Simulation exited with status $simStatus"
fi

if echo "$simOut" | grep -qx "all tests passed"; then
   exit 0
fi
echo "Pass line not found in simulation output"
exit 1

/* verif/dzTb.sv */
// Testbench for the DZ11-style multiplexer with bus and line tasks, a silo model and checked scenarios
`timescale 1ns/1ps

module dzTb;

   import dzPkg::*;

   logic              clk;
   logic              rst;
   logic              busRead;
   logic              busWrite;
   logic [ADDR_W-1:0] busAddr;
   logic [BUS_W-1:0]  busWData;
   logic [BUS_W-1:0]  busRData;
   logic              rxStrobe;
   logic [LINE_W-1:0] rxLine;
   logic [CHAR_W-1:0] rxData;
   logic              txStrobe;
   logic [LINE_W-1:0] txLine;
   logic [CHAR_W-1:0] txData;
   logic              iack;
   logic              vectRead;
   logic              rxIntr;
   logic              txIntr;
   logic              rxVector;

   // Reference state, LCG and expected silo contents
   logic [31:0]       lcgState;
   logic              mseModel;
   rxEntry            siloModel [$];

   dzTop dut0 (
      .clk, .rst, .busRead, .busWrite, .busAddr, .busWData, .busRData,
      .rxStrobe, .rxLine, .rxData, .txStrobe, .txLine, .txData,
      .iack, .vectRead, .rxIntr, .txIntr, .rxVector
   );

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   //////////////////////////////
   // Concurrent checks
   //////////////////////////////

   // Sampled mid cycle, where every signal is settled
   // A transmit strobe only follows a TDR write
   assert property (@(negedge clk) disable iff (rst)
      txStrobe |-> $past(busWrite) && $past(busAddr) == ADDR_TDR)
   else abortRun("txStrobe seen without a TDR write in the cycle before");

   // One strobe per write, never two in a row
   assert property (@(negedge clk) disable iff (rst) txStrobe |=> !txStrobe)
   else abortRun("txStrobe stayed high for two cycles");

   // Chosen request drops two cycles after vectRead falls
   assert property (@(negedge clk) disable iff (rst)
      ($past(vectRead, 3) && !$past(vectRead, 2) && $past(rxVector, 2)) |-> !rxIntr)
   else abortRun("rxIntr still high two cycles after the vector cycle");

   assert property (@(negedge clk) disable iff (rst)
      ($past(vectRead, 3) && !$past(vectRead, 2) && !$past(rxVector, 2)) |-> !txIntr)
   else abortRun("txIntr still high two cycles after the vector cycle");

   //////////////////////////////
   // Helpers
   //////////////////////////////

   // Numerical Recipes LCG constants
   function automatic logic [31:0] nextRand();
      lcgState = lcgState * 32'd1664525 + 32'd1013904223;
      return lcgState;
   endfunction

   function automatic logic [BUS_W-1:0] csrValue(input logic m, input logic r,
                                                 input logic t, input logic c);
      logic [BUS_W-1:0] v;
      v          = '0;
      v[CSR_MSE] = m;
      v[CSR_RIE] = r;
      v[CSR_TIE] = t;
      v[CSR_CLR] = c;
      return v;
   endfunction

   // Valid bit, line and character as the host sees them
   function automatic logic [BUS_W-1:0] rbufValue(input rxEntry e);
      logic [BUS_W-1:0] v;
      v                           = '0;
      v[RBUF_VALID]               = 1'b1;
      v[RBUF_LINE +: LINE_W]      = e.line;
      v[RBUF_DATA +: CHAR_W]      = e.data;
      return v;
   endfunction

   // First enabled line at or after start, the line counter wraps at NUM_LINES
   function automatic logic [LINE_W-1:0] nextLine(input logic [NUM_LINES-1:0] en,
                                                  input logic [LINE_W-1:0] start);
      logic [LINE_W-1:0] probe;
      logic [LINE_W-1:0] pick;
      logic              hit;
      probe = start;
      pick  = start;
      hit   = 1'b0;
      for (int i = 0; i < NUM_LINES; i++)
      begin
         if (!hit && en[probe])
         begin
            hit  = 1'b1;
            pick = probe;
         end
         probe = probe + 1'b1;
      end
      return pick;
   endfunction

   function automatic logic outputByName(input string name);
      if (name == "rxIntr")
         return rxIntr;
      else if (name == "txIntr")
         return txIntr;
      else
         return txStrobe;
   endfunction

   task automatic abortRun(input string why);
      $display("%s", why);
      $display("tests failed");
      $fatal(1);
   endtask

   task automatic checkValue(input string name, input logic [BUS_W-1:0] got,
                             input logic [BUS_W-1:0] exp);
      assert (got === exp)
      else abortRun($sformatf("** Error: %s = 0x%h, expected 0x%h", name, got, exp));
   endtask

   task automatic checkBit(input string name, input logic got, input logic exp);
      assert (got === exp)
      else abortRun($sformatf("** Error: %s = 0x%h, expected 0x%h", name, got, exp));
   endtask

   // Poll at each negedge until the output reaches the level
   task automatic waitLevel(input string name, input logic level);
      int n;
      n = 0;
      do
      begin
         @(negedge clk);
         n++;
         if (n > 50)
            abortRun($sformatf("timeout waiting for %s to go to %0d", name, level));
      end
      while (outputByName(name) !== level);
   endtask

   //////////////////////////////
   // Bus and line tasks
   //////////////////////////////

   task automatic writeReg(input logic [ADDR_W-1:0] a, input logic [BUS_W-1:0] d);
      @(posedge clk);
      busWrite <= 1'b1;
      busAddr  <= a;
      busWData <= d;
      @(posedge clk);
      busWrite <= 1'b0;
   endtask

   // Read data is registered, valid the cycle after the strobe
   task automatic readReg(input logic [ADDR_W-1:0] a, output logic [BUS_W-1:0] d);
      @(posedge clk);
      busRead <= 1'b1;
      busAddr <= a;
      @(posedge clk);
      busRead <= 1'b0;
      @(negedge clk);
      d = busRData;
   endtask

   task automatic setCsr(input logic m, input logic r, input logic t);
      writeReg(ADDR_CSR, csrValue(m, r, t, 1'b0));
      mseModel = m;
   endtask

   // clr lands one cycle after the write
   task automatic clearDevice();
      writeReg(ADDR_CSR, csrValue(1'b0, 1'b0, 1'b0, 1'b1));
      mseModel = 1'b0;
      siloModel.delete();
      @(posedge clk);
   endtask

   task automatic sendChar(input logic [LINE_W-1:0] line, input logic [CHAR_W-1:0] data);
      rxEntry e;
      e.line = line;
      e.data = data;
      @(posedge clk);
      rxStrobe <= 1'b1;
      rxLine   <= line;
      rxData   <= data;
      @(posedge clk);
      rxStrobe <= 1'b0;
      // Dropped while scanning is off or the silo is full
      if (mseModel && siloModel.size() < SILO_DEPTH)
         siloModel.push_back(e);
   endtask

   task automatic sendRandom();
      logic [31:0] r;
      r = nextRand();
      sendChar(r[18:16], r[26:19]);
   endtask

   task automatic checkRbufRead();
      logic [BUS_W-1:0] word;
      readReg(ADDR_RBUF, word);
      if (siloModel.size() == 0)
         checkValue("RBUF", word, '0);
      else
         checkValue("RBUF", word, rbufValue(siloModel.pop_front()));
   endtask

   // iack pulse, then vectRead across the vector cycle
   task automatic acknowledge(output logic vec);
      @(posedge clk);
      @(posedge clk);
      iack <= 1'b1;
      @(posedge clk);
      iack     <= 1'b0;
      vectRead <= 1'b1;
      @(posedge clk);
      @(negedge clk);
      vec = rxVector;
      @(posedge clk);
      vectRead <= 1'b0;
   endtask

   task automatic checkIdleOutputs();
      checkBit("rxIntr", rxIntr, 1'b0);
      checkBit("txIntr", txIntr, 1'b0);
      checkBit("rxVector", rxVector, 1'b0);
      checkBit("txStrobe", txStrobe, 1'b0);
      checkValue("busRData", busRData, '0);
   endtask

   //////////////////////////////
   // Scenarios
   //////////////////////////////

   initial
   begin
      logic [BUS_W-1:0]     word;
      logic [31:0]          r;
      logic [NUM_LINES-1:0] enables;
      logic [LINE_W-1:0]    expLine;
      logic [CHAR_W-1:0]    byteOut;
      logic                 vec;
      int                   n;

      lcgState = 32'hdbdf;
      mseModel = 1'b0;
      rst      = 1'b1;
      busRead  = 1'b0;
      busWrite = 1'b0;
      busAddr  = '0;
      busWData = '0;
      rxStrobe = 1'b0;
      rxLine   = '0;
      rxData   = '0;
      iack     = 1'b0;
      vectRead = 1'b0;
      repeat (3) @(posedge clk);
      rst <= 1'b0;

      // Reset state, then load some state and wipe it with clr
      @(negedge clk);
      checkIdleOutputs();
      readReg(ADDR_CSR, word);
      checkValue("CSR", word, '0);
      readReg(ADDR_TCR, word);
      checkValue("TCR", word, '0);
      writeReg(ADDR_TCR, BUS_W'(8'hff));
      setCsr(1'b1, 1'b1, 1'b1);
      repeat (2) sendRandom();
      waitLevel("rxIntr", 1'b1);
      waitLevel("txIntr", 1'b1);
      // Line 0 is first in the scan
      readReg(ADDR_CSR, word);
      checkValue("CSR", word, csrValue(1'b1, 1'b1, 1'b1, 1'b0) |
                 (BUS_W'(1) << CSR_RDONE) | (BUS_W'(1) << CSR_TRDY));
      // Leave rxVector high and the receive request raised again before clr
      acknowledge(vec);
      checkBit("rxVector", vec, 1'b1);
      waitLevel("rxIntr", 1'b0);
      checkRbufRead();
      waitLevel("rxIntr", 1'b1);
      clearDevice();
      @(negedge clk);
      checkIdleOutputs();
      readReg(ADDR_CSR, word);
      checkValue("CSR", word, '0);
      readReg(ADDR_TCR, word);
      checkValue("TCR", word, '0);

      // Receive order, mse gating and silo overflow
      repeat (2) sendRandom();
      setCsr(1'b1, 1'b0, 1'b0);
      repeat (SILO_DEPTH + 2) sendRandom();
      readReg(ADDR_CSR, word);
      checkValue("CSR", word, csrValue(1'b1, 1'b0, 1'b0, 1'b0) | (BUS_W'(1) << CSR_RDONE));
      repeat (SILO_DEPTH + 1) checkRbufRead();

      // Receive interrupt held off until the RBUF read
      setCsr(1'b1, 1'b1, 1'b0);
      repeat (2) sendRandom();
      waitLevel("rxIntr", 1'b1);
      acknowledge(vec);
      checkBit("rxVector", vec, 1'b1);
      waitLevel("rxIntr", 1'b0);
      repeat (4)
      begin
         @(negedge clk);
         checkBit("rxIntr", rxIntr, 1'b0);
      end
      checkRbufRead();
      waitLevel("rxIntr", 1'b1);

      // Round-robin transmit over a random line set
      clearDevice();
      r       = nextRand();
      enables = r[23:16];
      if (enables == '0)
         enables = NUM_LINES'(1);
      writeReg(ADDR_TCR, BUS_W'(enables));
      setCsr(1'b0, 1'b0, 1'b1);
      expLine = nextLine(enables, '0);
      repeat (10)
      begin
         n    = 0;
         word = '0;
         while (!word[CSR_TRDY])
         begin
            readReg(ADDR_CSR, word);
            n++;
            if (n > 20)
               abortRun("timeout waiting for trdy in CSR");
         end
         checkValue("CSR.tline", BUS_W'(word[CSR_TLINE +: LINE_W]), BUS_W'(expLine));
         checkBit("txIntr", txIntr, 1'b1);
         r       = nextRand();
         byteOut = r[31:24];
         writeReg(ADDR_TDR, BUS_W'(byteOut));
         waitLevel("txStrobe", 1'b1);
         checkValue("txLine", BUS_W'(txLine), BUS_W'(expLine));
         checkValue("txData", BUS_W'(txData), BUS_W'(byteOut));
         expLine = nextLine(enables, expLine + 1'b1);
      end
      // No line enabled, a TDR write goes nowhere
      writeReg(ADDR_TCR, '0);
      readReg(ADDR_CSR, word);
      checkBit("CSR.trdy", word[CSR_TRDY], 1'b0);
      writeReg(ADDR_TDR, BUS_W'(8'h5a));
      repeat (4)
      begin
         @(negedge clk);
         checkBit("txStrobe", txStrobe, 1'b0);
      end

      // Both pending, receive wins the first acknowledge
      clearDevice();
      writeReg(ADDR_TCR, BUS_W'(enables));
      setCsr(1'b1, 1'b1, 1'b1);
      sendRandom();
      waitLevel("rxIntr", 1'b1);
      waitLevel("txIntr", 1'b1);
      acknowledge(vec);
      checkBit("rxVector", vec, 1'b1);
      waitLevel("rxIntr", 1'b0);
      checkBit("txIntr", txIntr, 1'b1);
      acknowledge(vec);
      checkBit("rxVector", vec, 1'b0);
      waitLevel("txIntr", 1'b0);

      // Enables mask the outputs, pending state survives
      clearDevice();
      writeReg(ADDR_TCR, BUS_W'(enables));
      setCsr(1'b1, 1'b1, 1'b1);
      sendRandom();
      waitLevel("rxIntr", 1'b1);
      waitLevel("txIntr", 1'b1);
      setCsr(1'b1, 1'b0, 1'b1);
      @(negedge clk);
      checkBit("rxIntr", rxIntr, 1'b0);
      checkBit("txIntr", txIntr, 1'b1);
      setCsr(1'b1, 1'b1, 1'b1);
      @(negedge clk);
      checkBit("rxIntr", rxIntr, 1'b1);
      setCsr(1'b1, 1'b1, 1'b0);
      @(negedge clk);
      checkBit("txIntr", txIntr, 1'b0);
      checkBit("rxIntr", rxIntr, 1'b1);
      setCsr(1'b1, 1'b1, 1'b1);
      @(negedge clk);
      checkBit("txIntr", txIntr, 1'b1);

      $display("all tests passed");
      $finish;
   end

endmodule

/* design/dzTop.sv */
// DZ11-style multiplexer top, register block, receive silo, transmit scanner and interrupts
`timescale 1ns/1ps

module dzTop
(
   input  logic                     clk,
   input  logic                     rst,
   // Bus side
   input  logic                     busRead,
   input  logic                     busWrite,
   input  logic [dzPkg::ADDR_W-1:0] busAddr,
   input  logic [dzPkg::BUS_W-1:0]  busWData,
   output logic [dzPkg::BUS_W-1:0]  busRData,
   // Line side
   input  logic                     rxStrobe,
   input  logic [dzPkg::LINE_W-1:0] rxLine,
   input  logic [dzPkg::CHAR_W-1:0] rxData,
   output logic                     txStrobe,
   output logic [dzPkg::LINE_W-1:0] txLine,
   output logic [dzPkg::CHAR_W-1:0] txData,
   // Interrupt side
   input  logic                     iack,
   input  logic                     vectRead,
   output logic                     rxIntr,
   output logic                     txIntr,
   output logic                     rxVector
);

   import dzPkg::*;

   rxEntry                 wrEntry;
   rxEntry                 rdEntry;
   intrCtl                 ctl;
   logic                   push;
   logic                   pop;
   logic                   empty;
   logic                   full;
   logic [NUM_LINES-1:0]   lineEnable;
   logic                   tdrWrite;
   logic                   rbufRead;
   logic                   trdy;
   logic [LINE_W-1:0]      tline;
   logic                   clr;

   dzRegs regs0 (
      .clk, .rst, .busRead, .busWrite, .busAddr, .busWData, .busRData,
      .rxStrobe, .rxLine, .rxData, .push, .pop, .wrEntry, .rdEntry, .empty, .full,
      .lineEnable, .tdrWrite, .trdy, .tline, .clr, .rbufRead, .ctl,
      .txStrobe, .txLine, .txData
   );

   // Receive silo
   dzSilo silo0 (
      .clk, .rst, .clr, .push, .pop, .wrEntry, .rdEntry, .empty, .full
   );

   dzTxScan scan0 (
      .clk, .rst, .clr, .tdrWrite, .lineEnable, .trdy, .tline
   );

   dzIntr intr0 (
      .clk, .rst, .clr, .ctl, .iack, .vectRead, .rbufRead, .tdrWrite,
      .rxIntr, .txIntr, .rxVector
   );

endmodule

/* design/dzRegs.sv */
// Bus register block, CSR RBUF TCR TDR decode, clear pulse, silo strobes and transmit character
`timescale 1ns/1ps

module dzRegs
(
   input  logic                        clk,
   input  logic                        rst,
   input  logic                        busRead,
   input  logic                        busWrite,
   input  logic [dzPkg::ADDR_W-1:0]    busAddr,
   input  logic [dzPkg::BUS_W-1:0]     busWData,
   output logic [dzPkg::BUS_W-1:0]     busRData,
   input  logic                        rxStrobe,
   input  logic [dzPkg::LINE_W-1:0]    rxLine,
   input  logic [dzPkg::CHAR_W-1:0]    rxData,
   output logic                        push,
   output logic                        pop,
   output dzPkg::rxEntry               wrEntry,
   input  dzPkg::rxEntry               rdEntry,
   input  logic                        empty,
   input  logic                        full,
   output logic [dzPkg::NUM_LINES-1:0] lineEnable,
   output logic                        tdrWrite,
   input  logic                        trdy,
   input  logic [dzPkg::LINE_W-1:0]    tline,
   output logic                        clr,
   output logic                        rbufRead,
   output dzPkg::intrCtl               ctl,
   output logic                        txStrobe,
   output logic [dzPkg::LINE_W-1:0]    txLine,
   output logic [dzPkg::CHAR_W-1:0]    txData
);

   import dzPkg::*;

   logic             csrSel;
   logic             tcrSel;
   logic             mse;
   logic             rie;
   logic             tie;
   logic [BUS_W-1:0] csrWord;
   logic [BUS_W-1:0] rbufWord;
   logic [BUS_W-1:0] rdMux;

   // Address decode and access strobes
   assign csrSel   = busAddr == ADDR_CSR;
   assign tcrSel   = busAddr == ADDR_TCR;
   assign rbufRead = busRead && (busAddr == ADDR_RBUF);
   assign tdrWrite = busWrite && (busAddr == ADDR_TDR);

   // Silo side, characters only enter while scanning is enabled
   assign wrEntry = '{line: rxLine, data: rxData};
   assign push    = rxStrobe && mse && !full;
   assign pop     = rbufRead && !empty;

   assign ctl = '{rie: rie, rrdy: !empty, tie: tie, trdy: trdy};

   //////////////////////////////
   // CSR and TCR
   //////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         clr <= 1'b0;
      else
         clr <= busWrite && csrSel && busWData[CSR_CLR];
   end

   // clr wipes the enables the cycle after the clearing write
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst || clr)
      begin
         mse        <= 1'b0;
         rie        <= 1'b0;
         tie        <= 1'b0;
         lineEnable <= '0;
      end
      else if (busWrite && csrSel)
      begin
         mse <= busWData[CSR_MSE];
         rie <= busWData[CSR_RIE];
         tie <= busWData[CSR_TIE];
      end
      else if (busWrite && tcrSel)
         lineEnable <= busWData[NUM_LINES-1:0];
   end

   //////////////////////////////
   // Read data
   //////////////////////////////

   always_comb
   begin
      csrWord                      = '0;
      csrWord[CSR_MSE]             = mse;
      csrWord[CSR_RIE]             = rie;
      csrWord[CSR_RDONE]           = !empty;
      csrWord[CSR_TLINE +: LINE_W] = tline;
      csrWord[CSR_TIE]             = tie;
      csrWord[CSR_TRDY]            = trdy;
      // Empty silo reads back as all zero
      rbufWord = '0;
      if (!empty)
      begin
         rbufWord[RBUF_VALID]            = 1'b1;
         rbufWord[RBUF_LINE +: LINE_W]   = rdEntry.line;
         rbufWord[RBUF_DATA +: CHAR_W]   = rdEntry.data;
      end
      case (busAddr)
         ADDR_CSR:  rdMux = csrWord;
         ADDR_RBUF: rdMux = rbufWord;
         ADDR_TCR:  rdMux = BUS_W'(lineEnable);
         default:   rdMux = '0;   // TDR is write only
      endcase
   end

   // Read data registered, held until the next read
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst || clr)
         busRData <= '0;
      else if (busRead)
         busRData <= rdMux;
   end

   //////////////////////////////
   // Transmit character
   //////////////////////////////

   // TDR write only counts while a line is ready
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst || clr)
         txStrobe <= 1'b0;
      else
         txStrobe <= tdrWrite && trdy;
   end

   always_ff @(posedge clk)
   begin
      if (tdrWrite && trdy)
      begin
         txLine <= tline;
         txData <= busWData[CHAR_W-1:0];
      end
   end

endmodule

/* design/dzIntr.sv */
// Receive and transmit interrupt request FSMs with the receive-first acknowledge arbiter
`timescale 1ns/1ps

module dzIntr
(
   input  logic          clk,
   input  logic          rst,
   input  logic          clr,
   input  dzPkg::intrCtl ctl,
   input  logic          iack,
   input  logic          vectRead,
   input  logic          rbufRead,
   input  logic          tdrWrite,
   output logic          rxIntr,
   output logic          txIntr,
   output logic          rxVector
);

   // Request life cycle, shared by both directions
   typedef enum logic [1:0] {
      reqIdle,
      reqActive,
      reqWait,
      reqDone
   } reqStateT;

   // Arbiter follows one acknowledge sequence at a time
   typedef enum logic [2:0] {
      arbIdle,
      arbIack,
      arbVect,
      arbVectEnd,
      arbRxRetire,
      arbTxRetire
   } arbStateT;

   reqStateT   reqState [2];
   arbStateT   arbState;
   logic [1:0] reqEnable;
   logic [1:0] reqSet;
   logic [1:0] reqServed;
   logic [1:0] reqRetire;
   logic [1:0] reqPending;

   // Slot 0 is receive, slot 1 is transmit
   assign reqEnable = {ctl.tie, ctl.rie};
   assign reqSet    = {ctl.trdy, ctl.rrdy} & reqEnable;
   // RBUF read or TDR write is the service access
   assign reqServed = {tdrWrite, rbufRead};
   assign reqRetire = {arbState == arbTxRetire, arbState == arbRxRetire};

   //////////////////////////////
   // Request FSMs
   //////////////////////////////

   // Active until retired by the arbiter, then wait for the service access
   // and hold off a new request until that strobe has ended
   always_ff @(posedge clk or posedge rst)
   begin
      for (int i = 0; i < 2; i++)
      begin
         if (rst || clr)
            reqState[i] <= reqIdle;
         else
            case (reqState[i])
               reqIdle:
                  if (reqSet[i])
                     reqState[i] <= reqActive;
               reqActive:
                  if (reqRetire[i])
                     reqState[i] <= reqWait;
               reqWait:
                  if (reqServed[i])
                     reqState[i] <= reqDone;
               default:
                  if (!reqServed[i])
                     reqState[i] <= reqIdle;
            endcase
      end
   end

   assign reqPending[0] = reqState[0] == reqActive;
   assign reqPending[1] = reqState[1] == reqActive;

   // Enable masks the output only, the pending state survives
   assign rxIntr = reqPending[0] && reqEnable[0];
   assign txIntr = reqPending[1] && reqEnable[1];

   //////////////////////////////
   // Acknowledge arbiter
   //////////////////////////////

   // rxIntr is sampled at iack, receive wins when both are up
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         arbState <= arbIdle;
         rxVector <= 1'b0;
      end
      else if (clr)
      begin
         arbState <= arbIdle;
         rxVector <= 1'b0;
      end
      else
         case (arbState)
            arbIdle:
               if (|reqPending)
                  arbState <= arbIack;
            arbIack:
               if (iack)
               begin
                  rxVector <= rxIntr;
                  arbState <= arbVect;
               end
            arbVect:
               if (vectRead)
                  arbState <= arbVectEnd;
            arbVectEnd:
               // End of the vector cycle selects the request to retire
               if (!vectRead)
                  arbState <= rxVector ? arbRxRetire : arbTxRetire;
            default:
               arbState <= arbIdle;
         endcase
   end

endmodule

/* design/dzTxScan.sv */
// Transmit scanner, round-robin search over enabled lines giving trdy and tline
`timescale 1ns/1ps

module dzTxScan
(
   input  logic                       clk,
   input  logic                       rst,
   input  logic                       clr,
   input  logic                       tdrWrite,
   input  logic [dzPkg::NUM_LINES-1:0] lineEnable,
   output logic                       trdy,
   output logic [dzPkg::LINE_W-1:0]    tline
);

   import dzPkg::*;

   logic [LINE_W-1:0] scanPtr;
   logic [LINE_W-1:0] probe;
   logic [LINE_W-1:0] foundLine;
   logic              found;

   // First enabled line at or after scanPtr, wrapping
   always_comb
   begin
      found     = 1'b0;
      foundLine = scanPtr;
      probe     = scanPtr;
      for (int i = 0; i < NUM_LINES; i++)
      begin
         probe = LINE_W'((int'(scanPtr) + i) % NUM_LINES);
         if (!found && lineEnable[probe])
         begin
            found     = 1'b1;
            foundLine = probe;
         end
      end
   end

   //////////////////////////////
   // Scan state
   //////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst || clr)
      begin
         trdy    <= 1'b0;
         tline   <= '0;
         scanPtr <= '0;
      end
      else if (trdy)
      begin
         // Served line done, resume the search just past it
         if (tdrWrite)
         begin
            trdy    <= 1'b0;
            scanPtr <= (tline == LINE_W'(NUM_LINES - 1)) ? '0 : tline + 1'b1;
         end
         // Held line disabled under us, search again from it
         else if (!lineEnable[tline])
         begin
            trdy    <= 1'b0;
            scanPtr <= tline;
         end
      end
      else if (found)
      begin
         tline <= foundLine;
         trdy  <= 1'b1;
      end
   end

endmodule

/* design/dzSilo.sv */
// Receive silo, circular FIFO of tagged characters with empty and full flags
`timescale 1ns/1ps

module dzSilo
(
   input  logic          clk,
   input  logic          rst,
   input  logic          clr,
   input  logic          push,
   input  logic          pop,
   input  dzPkg::rxEntry wrEntry,
   output dzPkg::rxEntry rdEntry,
   output logic          empty,
   output logic          full
);

   import dzPkg::*;

   rxEntry                mem [SILO_DEPTH];
   logic [SILO_PTR_W-1:0] wrPtr;
   logic [SILO_PTR_W-1:0] rdPtr;
   logic [SILO_CNT_W-1:0] count;
   logic                  doPush;
   logic                  doPop;

   // Pointer step with wrap at the silo depth
   function automatic logic [SILO_PTR_W-1:0] nextPtr(input logic [SILO_PTR_W-1:0] ptr);
      return (ptr == SILO_PTR_W'(SILO_DEPTH - 1)) ? '0 : ptr + 1'b1;
   endfunction

   // Push into a full silo or pop from an empty one is ignored
   assign doPush = push && !full;
   assign doPop  = pop && !empty;

   // Character storage
   always_ff @(posedge clk)
   begin
      if (doPush)
         mem[wrPtr] <= wrEntry;
   end

   // Pointers and occupancy
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst || clr)
      begin
         wrPtr <= '0;
         rdPtr <= '0;
         count <= '0;
      end
      else
      begin
         if (doPush)
            wrPtr <= nextPtr(wrPtr);
         if (doPop)
            rdPtr <= nextPtr(rdPtr);
         // Simultaneous push and pop leaves count alone
         if (doPush && !doPop)
            count <= count + 1'b1;
         else if (doPop && !doPush)
            count <= count - 1'b1;
      end
   end

   // Oldest character is always on the read port
   assign rdEntry = mem[rdPtr];
   assign empty   = count == '0;
   assign full    = count == SILO_CNT_W'(SILO_DEPTH);

endmodule

/* design/dzPkg.sv */
// Sizes, bus register map, CSR and RBUF field positions, silo entry and interrupt condition types
package dzPkg;

   //////////////////////////////
   // Sizes
   //////////////////////////////

   // Eight character lines, three bit line number
   localparam int NUM_LINES  = 8;
   localparam int LINE_W     = 3;
   localparam int CHAR_W     = 8;
   // Bus data and register address widths
   localparam int BUS_W      = 16;
   localparam int ADDR_W     = 2;
   // Receive silo sizing
   localparam int SILO_DEPTH = 8;
   localparam int SILO_PTR_W = $clog2(SILO_DEPTH);
   localparam int SILO_CNT_W = $clog2(SILO_DEPTH + 1);

   //////////////////////////////
   // Register map
   //////////////////////////////

   localparam logic [ADDR_W-1:0] ADDR_CSR  = 2'd0;
   localparam logic [ADDR_W-1:0] ADDR_RBUF = 2'd1;
   localparam logic [ADDR_W-1:0] ADDR_TCR  = 2'd2;
   localparam logic [ADDR_W-1:0] ADDR_TDR  = 2'd3;

   // CSR bits, clr always reads back as zero
   localparam int CSR_CLR   = 4;
   localparam int CSR_MSE   = 5;
   localparam int CSR_RIE   = 6;
   localparam int CSR_RDONE = 7;
   // Low bit of the three bit tline field
   localparam int CSR_TLINE = 8;
   localparam int CSR_TIE   = 14;
   localparam int CSR_TRDY  = 15;

   // RBUF layout
   localparam int RBUF_VALID = 15;
   localparam int RBUF_LINE  = 8;
   localparam int RBUF_DATA  = 0;

   // One received character tagged with its line
   typedef struct packed {
      logic [LINE_W-1:0] line;
      logic [CHAR_W-1:0] data;
   } rxEntry;

   // Interrupt conditions toward the interrupt controller
   typedef struct packed {
      logic rie;
      logic rrdy;
      logic tie;
      logic trdy;
   } intrCtl;

endpackage
